// ==== hdl/cfir_defines.svh ====
/*
 * Sizing of the complex FIR. All widths are signed two's complement.
 * The output keeps full precision, so a result never wraps.
 * Changing the tap count past 16 needs more guard bits in the sum width.
 */
`ifndef CFIR_DEFINES_SVH
`define CFIR_DEFINES_SVH

// Number of filter taps, and so the depth of the coefficient bank and the delay line.
`define CFIR_TAPS 12

// Width of one real or imaginary part of a sample or a coefficient.
`define CFIR_DATA_WIDTH 8

// A single real product needs the two operand widths added together.
`define CFIR_PROD_WIDTH (2 * `CFIR_DATA_WIDTH)

// Four guard bits cover the growth from summing up to 16 taps.
`define CFIR_SUM_WIDTH (`CFIR_PROD_WIDTH + 4)

// One more bit for the final add or subtract of two sums.
`define CFIR_OUT_WIDTH (`CFIR_SUM_WIDTH + 1)

`endif

// ==== hdl/cfirPkg.sv ====
/*
 * Types shared by the filter stages and the testbench.
 * Every numeric field is signed, so arithmetic on fields sign-extends.
 */
`include "cfir_defines.svh"

package cfirPkg;

	// One complex value. Samples and coefficients share this layout.
	typedef struct packed {
		logic signed [`CFIR_DATA_WIDTH-1:0] re;
		logic signed [`CFIR_DATA_WIDTH-1:0] im;
	} complexSample;

	// The four real products that make up one complex multiply.
	// The first name is the sample part, the second the coefficient part.
	typedef struct packed {
		logic signed [`CFIR_PROD_WIDTH-1:0] reRe;
		logic signed [`CFIR_PROD_WIDTH-1:0] reIm;
		logic signed [`CFIR_PROD_WIDTH-1:0] imRe;
		logic signed [`CFIR_PROD_WIDTH-1:0] imIm;
	} tapProducts;

	// A full precision filter output.
	typedef struct packed {
		logic signed [`CFIR_OUT_WIDTH-1:0] re;
		logic signed [`CFIR_OUT_WIDTH-1:0] im;
	} complexResult;

	// Operating modes of the filter, in the order they are visited.
	typedef enum logic [1:0] {
		idle       = 2'd0,
		loadCoeffs = 2'd1,
		run        = 2'd2,
		stop       = 2'd3
	} filterMode;

endpackage

// ==== hdl/coeffSequencer.sv ====
/*
 * Mode FSM and coefficient bank. Coefficients shift in one per clock while loading,
 * including the cycle that sees coefficientsSet. Only the last CFIR_TAPS loaded
 * are kept, and the oldest of them becomes c0. There is no readback of the bank.
 */
`timescale 1ns/1ps
`include "cfir_defines.svh"

module coeffSequencer (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic                  loadCoefficients,
	input  logic                  coefficientsSet,
	input  logic                  stopDataLoad,
	input  cfirPkg::complexSample coeffIn,
	output cfirPkg::complexSample coeffs [0:`CFIR_TAPS-1],
	output logic                  running,
	output logic                  historyClear
);

	cfirPkg::filterMode    mode;
	cfirPkg::complexSample bank [0:`CFIR_TAPS-1];

	// Mode transitions. The clear pulse is raised for the first load cycle only.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			mode <= cfirPkg::idle;
			historyClear <= 1'b0;
		end else begin
			historyClear <= 1'b0;
			case (mode)
				cfirPkg::idle: begin
					if (loadCoefficients) begin
						mode <= cfirPkg::loadCoeffs;
						historyClear <= 1'b1;
					end
				end
				cfirPkg::loadCoeffs: begin
					if (coefficientsSet) begin
						mode <= cfirPkg::run;
					end
				end
				cfirPkg::run: begin
					if (stopDataLoad) begin
						mode <= cfirPkg::stop;
					end
				end
				// Stop lasts a single cycle.
				default: mode <= cfirPkg::idle;
			endcase
		end
	end

	// The newest coefficient enters at position 0 and older ones move up.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < `CFIR_TAPS; k++) begin
				bank[k] <= '0;
			end
		end else if (mode == cfirPkg::loadCoeffs) begin
			for (int k = `CFIR_TAPS - 1; k > 0; k--) begin
				bank[k] <= bank[k-1];
			end
			bank[0] <= coeffIn;
		end
	end

	// The oldest kept coefficient sits at the top of the bank, so reverse it.
	// After this, coeffs[k] multiplies the sample that is k strobes old.
	always_comb begin
		for (int k = 0; k < `CFIR_TAPS; k++) begin
			coeffs[k] = bank[`CFIR_TAPS - 1 - k];
		end
	end

	assign running = (mode == cfirPkg::run);

	// Modes are visited strictly in order, and stop wraps back to idle.
	modeInOrder: assert property (@(posedge clock) disable iff (!arstN)
		(mode != $past(mode)) |-> (mode == ($past(mode) + 2'd1)));

endmodule

// ==== hdl/tapDelayLine.sv ====
/*
 * Complex sample history. A sample is taken only while the filter runs.
 * The whole line is zeroed at the start of every coefficient load,
 * so each run starts from empty history.
 */
`timescale 1ns/1ps
`include "cfir_defines.svh"

module tapDelayLine (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic                  historyClear,
	input  logic                  running,
	input  logic                  loadData,
	input  cfirPkg::complexSample dataIn,
	output cfirPkg::complexSample taps [0:`CFIR_TAPS-1],
	output logic                  tapsValid
);

	logic takeSample;

	// Strobes outside run mode are ignored and leave the history alone.
	assign takeSample = loadData && running;

	// Position 0 holds the newest sample x[n], position k holds x[n-k].
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < `CFIR_TAPS; k++) begin
				taps[k] <= '0;
			end
		end else if (historyClear) begin
			for (int k = 0; k < `CFIR_TAPS; k++) begin
				taps[k] <= '0;
			end
		end else if (takeSample) begin
			for (int k = `CFIR_TAPS - 1; k > 0; k--) begin
				taps[k] <= taps[k-1];
			end
			taps[0] <= dataIn;
		end
	end

	// The valid marks the cycle in which the freshly shifted line is presented.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			tapsValid <= 1'b0;
		end else begin
			tapsValid <= takeSample;
		end
	end

	// A clear only comes at the start of a load, so no sample can be in
	// the line's output stage at the same time.
	clearNotWithValid: assert property (@(posedge clock) disable iff (!arstN)
		!(historyClear && tapsValid));

endmodule

// ==== hdl/tapMultiplier.sv ====
/*
 * First arithmetic stage. Every tap is multiplied by its coefficient as four
 * real products, registered in one cycle. The product registers have no reset
 * value and hold meaningful data only while productsValid is high.
 */
`timescale 1ns/1ps
`include "cfir_defines.svh"

module tapMultiplier (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic                  tapsValid,
	input  cfirPkg::complexSample taps   [0:`CFIR_TAPS-1],
	input  cfirPkg::complexSample coeffs [0:`CFIR_TAPS-1],
	output cfirPkg::tapProducts   products [0:`CFIR_TAPS-1],
	output logic                  productsValid
);

	cfirPkg::tapProducts nextProducts [0:`CFIR_TAPS-1];

	// Tap k pairs with coefficient k.
	// All fields are signed, so each product is a signed 16 by 16 multiply
	// of sign-extended 8 bit operands.
	always_comb begin
		for (int k = 0; k < `CFIR_TAPS; k++) begin
			nextProducts[k].reRe = taps[k].re * coeffs[k].re;
			nextProducts[k].reIm = taps[k].re * coeffs[k].im;
			nextProducts[k].imRe = taps[k].im * coeffs[k].re;
			nextProducts[k].imIm = taps[k].im * coeffs[k].im;
		end
	end

	// A new set of products is taken on every cycle, valid or not.
	// The stage thus never stalls and three samples can be in flight.
	always_ff @(posedge clock) begin
		for (int k = 0; k < `CFIR_TAPS; k++) begin
			products[k] <= nextProducts[k];
		end
	end

	// The valid moves along with the products it belongs to.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			productsValid <= 1'b0;
		end else begin
			productsValid <= tapsValid;
		end
	end

	// Coefficients may only change during a load, never while a sample
	// taken in run mode is on its way into the products.
	for (genvar k = 0; k < `CFIR_TAPS; k++) begin : coeffHoldGen
		coeffStable: assert property (@(posedge clock) disable iff (!arstN)
			tapsValid |-> $stable(coeffs[k]));
	end

endmodule

// ==== hdl/productSumTree.sv ====
/*
 * Final stage. Sums every product kind across the taps and forms the complex
 * result at full precision. dataOut changes only when outValid rises and
 * keeps its value in between. Nothing waits for a reader.
 */
`timescale 1ns/1ps
`include "cfir_defines.svh"

module productSumTree (
	input  logic                 clock,
	input  logic                 arstN,
	input  logic                 productsValid,
	input  cfirPkg::tapProducts  products [0:`CFIR_TAPS-1],
	output cfirPkg::complexResult dataOut,
	output logic                 outValid
);

	logic signed [`CFIR_SUM_WIDTH-1:0] sumReRe;
	logic signed [`CFIR_SUM_WIDTH-1:0] sumReIm;
	logic signed [`CFIR_SUM_WIDTH-1:0] sumImRe;
	logic signed [`CFIR_SUM_WIDTH-1:0] sumImIm;
	cfirPkg::complexResult             nextResult;

	// Each product is sign-extended to the sum width before it is added.
	always_comb begin
		sumReRe = '0;
		sumReIm = '0;
		sumImRe = '0;
		sumImIm = '0;
		for (int k = 0; k < `CFIR_TAPS; k++) begin
			sumReRe = sumReRe + products[k].reRe;
			sumReIm = sumReIm + products[k].reIm;
			sumImRe = sumImRe + products[k].imRe;
			sumImIm = sumImIm + products[k].imIm;
		end
	end

	// (a + jb)(c + jd) = (ac - bd) + j(ad + bc).
	// The extra output bit holds the carry of this last step.
	assign nextResult.re = sumReRe - sumImIm;
	assign nextResult.im = sumReIm + sumImRe;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			dataOut <= '0;
			outValid <= 1'b0;
		end else begin
			outValid <= productsValid;
			if (productsValid) begin
				dataOut <= nextResult;
			end
		end
	end

	// A result leaves together with its strobe, and every bit of it must be known then.
	resultKnown: assert property (@(posedge clock) disable iff (!arstN)
		outValid |-> !$isunknown(dataOut));

endmodule

// ==== hdl/complexFir.sv ====
/*
 * Complex FIR filter top. Load coefficients, then strobe samples in run mode.
 * A result appears a fixed 3 edges after its sample strobe, with outValid.
 * There is no back-pressure; results must be taken when they arrive.
 */
`timescale 1ns/1ps
`include "cfir_defines.svh"

module complexFir (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic                  loadCoefficients,
	input  logic                  coefficientsSet,
	input  cfirPkg::complexSample coeffIn,
	input  logic                  loadData,
	input  logic                  stopDataLoad,
	input  cfirPkg::complexSample dataIn,
	output cfirPkg::complexResult dataOut,
	output logic                  outValid
);

	cfirPkg::complexSample coeffs   [0:`CFIR_TAPS-1];
	cfirPkg::complexSample taps     [0:`CFIR_TAPS-1];
	cfirPkg::tapProducts   products [0:`CFIR_TAPS-1];
	logic                  running;
	logic                  historyClear;
	logic                  tapsValid;
	logic                  productsValid;

	// Modes and the coefficient bank.
	coeffSequencer sequencer_i (
		.clock, .arstN, .loadCoefficients, .coefficientsSet, .stopDataLoad,
		.coeffIn, .coeffs, .running, .historyClear
	);

	// Sample history, first pipeline stage.
	tapDelayLine delayLine_i (
		.clock, .arstN, .historyClear, .running, .loadData, .dataIn,
		.taps, .tapsValid
	);

	// Products, second pipeline stage.
	tapMultiplier multiplier_i (
		.clock, .arstN, .tapsValid, .taps, .coeffs, .products, .productsValid
	);

	// Sums and the complex combine, third pipeline stage.
	productSumTree sumTree_i (
		.clock, .arstN, .productsValid, .products, .dataOut, .outValid
	);

endmodule

// ==== dv/clockGen.sv ====
/*
 * Testbench clock of 10 ns period. The active low reset is held over the
 * first 2 rising edges and released right after the second.
 */
`timescale 1ns/1ps

module clockGen (
	output logic clock,
	output logic arstN
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// The release is a non-blocking update, so the flops still see reset at that edge.
	initial begin
		arstN <= 1'b0;
		repeat (2) @(posedge clock);
		arstN <= 1'b1;
	end

endmodule

// ==== dv/complexFirTb.sv ====
/*
 * Testbench for the complex FIR. A model follows the mode rules at every edge,
 * predicts each result at full precision and expects it 3 edges after its strobe.
 * Stimulus is random from a fixed seed, so every run is the same.
 */
`timescale 1ns/1ps
`include "cfir_defines.svh"

module complexFirTb;

	// Nominal cycles of the six tests; the run is cut off at twice that plus margin.
	localparam int testCycles = 20 + 50 + 700 + 90 + 60 + 50;
	localparam int cycleLimit = 2 * testCycles + 100;

	logic clock, arstN;
	logic loadCoefficients, coefficientsSet, loadData, stopDataLoad;
	cfirPkg::complexSample coeffIn, dataIn;
	cfirPkg::complexResult dataOut;
	logic outValid;

	integer seed = 32'h8143a502;
	int cycle = 0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int testStartErrors = 0;
	string testName = "reset";

	// Model state. Coefficient 0 is the oldest kept one, history 0 the newest sample.
	cfirPkg::filterMode modelMode;
	cfirPkg::complexSample modelCoef [0:`CFIR_TAPS-1];
	cfirPkg::complexSample modelHist [0:`CFIR_TAPS-1];
	cfirPkg::complexResult expectQ [$];
	int strobeCycleQ [$];

	clockGen clockGen_i (.clock, .arstN);

	complexFir dut_i (
		.clock, .arstN, .loadCoefficients, .coefficientsSet, .coeffIn,
		.loadData, .stopDataLoad, .dataIn, .dataOut, .outValid
	);

	function automatic cfirPkg::complexSample randomSample();
		cfirPkg::complexSample s;
		s.re = `CFIR_DATA_WIDTH'($random(seed));
		s.im = `CFIR_DATA_WIDTH'($random(seed));
		return s;
	endfunction

	// Each coefficient weights the sample that is as many strobes old as its index.
	// (a + jb)(c + jd) gives ac - bd for the real part and ad + bc for the imaginary.
	function automatic cfirPkg::complexResult modelOutput();
		cfirPkg::complexResult r;
		int accRe;
		int accIm;
		accRe = 0;
		accIm = 0;
		for (int k = 0; k < `CFIR_TAPS; k++) begin
			accRe += int'(modelHist[k].re) * int'(modelCoef[k].re)
				- int'(modelHist[k].im) * int'(modelCoef[k].im);
			accIm += int'(modelHist[k].re) * int'(modelCoef[k].im)
				+ int'(modelHist[k].im) * int'(modelCoef[k].re);
		end
		r.re = `CFIR_OUT_WIDTH'(accRe);
		r.im = `CFIR_OUT_WIDTH'(accIm);
		return r;
	endfunction

	task automatic checkResult(cfirPkg::complexResult expected, cfirPkg::complexResult actual);
		if (actual !== expected) begin
			errorCount++;
			$display("** Error %s: expected (%0d, %0d), actual (%0d, %0d)", testName,
				expected.re, expected.im, actual.re, actual.im);
		end
	endtask

	task automatic checkBit(string what, logic expected, logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("** Error %s: %s expected %b, actual %b", testName, what, expected, actual);
		end
	endtask

	task automatic reportProblem(string what);
		errorCount++;
		$display("%s: %s", testName, what);
	endtask

	// The model sees the inputs as the DUT samples them, before this edge's updates.
	// A pulse is checked first, then the model advances by one edge.
	always @(posedge clock) begin
		cycle++;
		if (!arstN) begin
			modelMode = cfirPkg::idle;
			modelCoef = '{default: '0};
			modelHist = '{default: '0};
		end else begin
			if (outValid && expectQ.size() == 0) begin
				reportProblem("outValid pulsed while no result was expected");
			end else if (outValid) begin
				if (cycle - strobeCycleQ.pop_front() != 3) begin
					reportProblem("a result did not arrive 3 edges after its strobe");
				end
				checkResult(expectQ.pop_front(), dataOut);
			end
			case (modelMode)
				cfirPkg::idle: begin
					if (loadCoefficients) begin
						modelMode = cfirPkg::loadCoeffs;
						modelHist = '{default: '0};
					end
				end
				cfirPkg::loadCoeffs: begin
					for (int k = 0; k < `CFIR_TAPS - 1; k++) modelCoef[k] = modelCoef[k + 1];
					modelCoef[`CFIR_TAPS - 1] = coeffIn;
					if (coefficientsSet) modelMode = cfirPkg::run;
				end
				cfirPkg::run: begin
					if (loadData) begin
						for (int k = `CFIR_TAPS - 1; k > 0; k--) modelHist[k] = modelHist[k - 1];
						modelHist[0] = dataIn;
						expectQ.push_back(modelOutput());
						strobeCycleQ.push_back(cycle);
					end
					if (stopDataLoad) modelMode = cfirPkg::stop;
				end
				default: modelMode = cfirPkg::idle;
			endcase
		end
	end

	task automatic driveCycle(logic strobe, cfirPkg::complexSample sample);
		@(posedge clock);
		loadData <= strobe;
		dataIn <= sample;
	endtask

	// Starts a load from idle and shifts in count coefficients, setting on the last.
	// With strobeDuring, loadData is also pulsed in idle and inside the load.
	task automatic loadBank(int count, logic strobeDuring);
		@(posedge clock);
		loadCoefficients <= 1'b1;
		loadData <= strobeDuring;
		for (int i = 0; i < count; i++) begin
			@(posedge clock);
			loadCoefficients <= 1'b0;
			coeffIn <= randomSample();
			coefficientsSet <= (i == count - 1);
			loadData <= strobeDuring && i[0];
			dataIn <= randomSample();
		end
		@(posedge clock);
		coefficientsSet <= 1'b0;
		loadData <= 1'b0;
	endtask

	// The last strobe goes with the stop, so it is still in flight afterwards.
	task automatic stopRun();
		@(posedge clock);
		loadData <= 1'b1;
		dataIn <= randomSample();
		stopDataLoad <= 1'b1;
		@(posedge clock);
		loadData <= 1'b0;
		stopDataLoad <= 1'b0;
		@(posedge clock);
	endtask

	// Latency is a fixed 3 edges, so six quiet cycles empty the pipeline.
	task automatic finishTest();
		repeat (6) driveCycle(1'b0, '0);
		@(negedge clock);
		if (expectQ.size() != 0) begin
			reportProblem($sformatf("%0d expected results never appeared", expectQ.size()));
			expectQ.delete();
			strobeCycleQ.delete();
		end
		if (errorCount == testStartErrors) begin
			passCount++;
			$display("Test %s passed", testName);
		end else begin
			failCount++;
			$display("Test %s failed with %0d errors", testName, errorCount - testStartErrors);
		end
	endtask

	task automatic startTest(string name);
		testName = name;
		testStartErrors = errorCount;
	endtask

	initial begin
		cfirPkg::complexSample sample;
		logic doStrobe;
		int sent;
		loadCoefficients <= 1'b0;
		coefficientsSet <= 1'b0;
		coeffIn <= '0;
		loadData <= 1'b0;
		stopDataLoad <= 1'b0;
		dataIn <= '0;
		wait (arstN === 1'b1);

		startTest("reset");
		repeat (10) begin
			@(posedge clock);
			checkBit("outValid", 1'b0, outValid);
			checkResult('0, dataOut);
		end
		finishTest();

		// A real unit impulse, then an imaginary one after the first has left the line.
		startTest("impulse");
		loadBank(`CFIR_TAPS, 1'b0);
		for (int i = 0; i < 2 * `CFIR_TAPS; i++) begin
			sample = '0;
			if (i == 0) sample.re = 1;
			if (i == `CFIR_TAPS) sample.im = 1;
			driveCycle(1'b1, sample);
		end
		finishTest();

		// Most negative parts are forced now and then, as they give the largest products.
		startTest("random stream");
		sent = 0;
		while (sent < 300) begin
			sample = randomSample();
			if (sent % 7 == 0) sample.re = {1'b1, {(`CFIR_DATA_WIDTH-1){1'b0}}};
			if (sent % 11 == 0) sample.im = {1'b1, {(`CFIR_DATA_WIDTH-1){1'b0}}};
			doStrobe = 1'($random(seed));
			driveCycle(doStrobe, sample);
			if (doStrobe) sent++;
		end
		finishTest();

		startTest("strobe spacing");
		for (int i = 0; i < 20; i++) driveCycle(1'b1, randomSample());
		for (int i = 0; i < 20; i++) begin
			driveCycle(1'b1, randomSample());
			repeat (1 + i % 3) driveCycle(1'b0, randomSample());
		end
		finishTest();

		// More coefficients than taps are loaded, so the first three fall out of the bank.
		startTest("reload");
		for (int i = 0; i < 3; i++) driveCycle(1'b1, randomSample());
		stopRun();
		loadBank(`CFIR_TAPS + 3, 1'b0);
		for (int i = 0; i < 30; i++) driveCycle(1'b1, randomSample());
		finishTest();

		startTest("strobes outside run");
		stopRun();
		for (int i = 0; i < 4; i++) driveCycle(1'b1, randomSample());
		loadBank(`CFIR_TAPS, 1'b1);
		for (int i = 0; i < 20; i++) driveCycle(1'b1, randomSample());
		finishTest();

		$display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		wait (cycle >= cycleLimit);
		$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/cfirPkg.sv
hdl/coeffSequencer.sv
hdl/tapDelayLine.sv
hdl/tapMultiplier.sv
hdl/productSumTree.sv
hdl/complexFir.sv
dv/clockGen.sv
dv/complexFirTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the complex FIR testbench with Verilator, runs it and checks the log.
# Warnings are still reported, but they do not stop the build.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal -f list.f --top-module complexFirTb -Mdir obj_dir &&
	./obj_dir/VcomplexFirTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '\*\* PASS \*\*' sim.log && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}
